//--- aud_dsp_config.svh
`ifndef AUD_DSP_CONFIG_SVH
`define AUD_DSP_CONFIG_SVH

// widths of the playback core, fixed by the SRAM and the codec

// SRAM word address, 1M x 16 part
`define AUD_ADDR_W 20

// signed PCM sample as read from SRAM and sent to the DAC
`define AUD_SAMPLE_W 16

// speed select pins
// fast play steps by speed + 1
// slow play stretches each sample over speed + 1 periods
`define AUD_SPEED_W 3

// slow-play phase counter, counts 0 .. speed
// must be as wide as the speed select
`define AUD_CNT_W 3

`endif

//--- aud_ctrl_pkg.sv
package aud_ctrl_pkg;

    // transport state of the player
    typedef enum logic [1:0] {
        IDLE,   // stopped, address parked at zero
        PLAY,   // stepping once per lrck period
        PAUSE   // everything frozen
    } play_state_e;

    // playback mode after priority decode of the mode pins
    // fast > slow hold > slow linear > normal
    typedef enum logic [1:0] {
        MODE_NORMAL,      // one new sample per period
        MODE_FAST,        // skip ahead by speed + 1
        MODE_SLOW_HOLD,   // zero-order hold of the current sample
        MODE_SLOW_LINEAR  // linear ramp between previous and current
    } play_mode_e;

endpackage

//--- aud_sample_pkg.sv
`include "aud_dsp_config.svh"

package aud_sample_pkg;

    // one audio sample, two's complement
    typedef logic signed [`AUD_SAMPLE_W-1:0] sample_t;

    // SRAM read address, unsigned
    // forward play wraps modulo 2^AUD_ADDR_W
    typedef logic [`AUD_ADDR_W-1:0] addr_t;

endpackage

//--- aud_play_ctrl.sv
`timescale 1ns/1ps

module aud_play_ctrl (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_start,
    input  logic                     i_pause,
    input  logic                     i_stop,
    input  logic                     i_daclrck,
    input  logic                     i_fast,
    input  logic                     i_slow_hold,
    input  logic                     i_slow_linear,
    output logic                     o_tick,
    output logic                     o_load_start,
    output logic                     o_clear,
    output aud_ctrl_pkg::play_mode_e o_play_mode
);

    aud_ctrl_pkg::play_state_e state_q;
    aud_ctrl_pkg::play_state_e state_d;
    logic                      daclrck_q;   // lrck one clock ago
    logic                      lrck_rise;

    // first clock in which lrck is seen high
    assign lrck_rise = i_daclrck && !daclrck_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q   <= aud_ctrl_pkg::IDLE;
            daclrck_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            daclrck_q <= i_daclrck;
        end
    end

    // transport FSM, stop beats pause beats the lrck edge
    always_comb begin
        state_d = state_q;
        case (state_q)
            aud_ctrl_pkg::IDLE: begin
                if (i_start) begin
                    state_d = aud_ctrl_pkg::PLAY;
                end
            end
            aud_ctrl_pkg::PLAY: begin
                if (i_stop) begin
                    state_d = aud_ctrl_pkg::IDLE;
                end else if (i_pause) begin
                    state_d = aud_ctrl_pkg::PAUSE;
                end
            end
            aud_ctrl_pkg::PAUSE: begin
                if (i_stop) begin
                    state_d = aud_ctrl_pkg::IDLE;
                end else if (i_start) begin
                    state_d = aud_ctrl_pkg::PLAY;   // resume where we left off
                end
            end
            default: state_d = aud_ctrl_pkg::IDLE;
        endcase
    end

    // one pulse per lrck period while playing
    assign o_tick = (state_q == aud_ctrl_pkg::PLAY) && lrck_rise && !i_stop && !i_pause;

    assign o_load_start = (state_q == aud_ctrl_pkg::IDLE) && i_start;

    assign o_clear = ((state_q == aud_ctrl_pkg::PLAY) || (state_q == aud_ctrl_pkg::PAUSE))
                     && i_stop;

    // mode pins by priority, hold wins when both slow pins are set
    always_comb begin
        if (i_fast) begin
            o_play_mode = aud_ctrl_pkg::MODE_FAST;
        end else if (i_slow_hold) begin
            o_play_mode = aud_ctrl_pkg::MODE_SLOW_HOLD;
        end else if (i_slow_linear) begin
            o_play_mode = aud_ctrl_pkg::MODE_SLOW_LINEAR;
        end else begin
            o_play_mode = aud_ctrl_pkg::MODE_NORMAL;
        end
    end

endmodule

//--- aud_sample_engine.sv
`timescale 1ns/1ps

`include "aud_dsp_config.svh"

module aud_sample_engine (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_tick,
    input  logic                     i_clear,
    input  aud_ctrl_pkg::play_mode_e i_play_mode,
    input  logic [`AUD_SPEED_W-1:0]  i_speed,
    input  aud_sample_pkg::sample_t  i_sram_data,
    output logic                     o_advance,
    output aud_sample_pkg::addr_t    o_step,
    output aud_sample_pkg::sample_t  o_dac_data
);

    // room for (curr - prev) * 8 without overflow
    localparam int EXT_W = `AUD_SAMPLE_W + `AUD_CNT_W + 3;

    logic [`AUD_CNT_W-1:0]   cnt_q;      // slow-play phase
    aud_sample_pkg::sample_t prev_q;
    aud_sample_pkg::sample_t curr_q;
    aud_sample_pkg::sample_t out_q;

    logic                    is_slow;
    logic                    slow_load;  // last phase of a slow sample
    logic signed [EXT_W-1:0] prev_x;
    logic signed [EXT_W-1:0] curr_x;
    logic signed [EXT_W-1:0] mul_x;
    logic signed [EXT_W-1:0] div_x;
    logic signed [EXT_W-1:0] interp_x;
    aud_sample_pkg::sample_t slow_out;

    assign is_slow = (i_play_mode == aud_ctrl_pkg::MODE_SLOW_HOLD) ||
                     (i_play_mode == aud_ctrl_pkg::MODE_SLOW_LINEAR);

    // >= so a speed change mid-sample cannot strand the counter
    assign slow_load = (cnt_q >= i_speed);

    // address control for aud_addr_gen
    assign o_advance = !is_slow || slow_load;
    assign o_step    = (i_play_mode == aud_ctrl_pkg::MODE_FAST)
                     ? aud_sample_pkg::addr_t'(i_speed) + aud_sample_pkg::addr_t'(1)
                     : aud_sample_pkg::addr_t'(1);

    // prev + (curr - prev) * (cnt + 1) / N, signed divide truncates toward zero
    always_comb begin
        prev_x   = EXT_W'(prev_q);              // sign extend
        curr_x   = EXT_W'(curr_q);
        mul_x    = EXT_W'(cnt_q) + EXT_W'(1);   // 1 .. 8
        div_x    = EXT_W'(i_speed) + EXT_W'(1); // N
        interp_x = prev_x + ((curr_x - prev_x) * mul_x) / div_x;
    end

    always_comb begin
        if ((i_play_mode == aud_ctrl_pkg::MODE_SLOW_HOLD) || (i_speed == '0)) begin
            slow_out = curr_q;
        end else begin
            slow_out = interp_x[`AUD_SAMPLE_W-1:0];   // wrap to sample width
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q  <= '0;
            prev_q <= '0;
            curr_q <= '0;
            out_q  <= '0;
        end else if (i_clear) begin
            cnt_q <= '0;          // samples survive a stop
        end else if (i_tick) begin
            case (i_play_mode)
                aud_ctrl_pkg::MODE_FAST: begin
                    curr_q <= i_sram_data;
                    out_q  <= i_sram_data;
                    cnt_q  <= '0;
                end
                aud_ctrl_pkg::MODE_NORMAL: begin
                    curr_q <= i_sram_data;
                    out_q  <= i_sram_data;
                end
                default: begin
                    // both slow shapes, output uses pre-update values
                    out_q <= slow_out;
                    if (slow_load) begin
                        prev_q <= curr_q;
                        curr_q <= i_sram_data;
                        cnt_q  <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
            endcase
        end
    end

    assign o_dac_data = out_q;

endmodule

//--- aud_addr_gen.sv
`timescale 1ns/1ps

module aud_addr_gen (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_tick,
    input  logic                  i_load_start,
    input  logic                  i_clear,
    input  logic                  i_backward,
    input  aud_sample_pkg::addr_t i_max_addr,
    input  logic                  i_advance,
    input  aud_sample_pkg::addr_t i_step,
    output aud_sample_pkg::addr_t o_sram_addr
);

    aud_sample_pkg::addr_t addr_q;
    aud_sample_pkg::addr_t addr_fwd;
    aud_sample_pkg::addr_t addr_bwd;
    aud_sample_pkg::addr_t addr_start;
    logic                  below_step;

    // forward just wraps at the top of the SRAM
    assign addr_fwd = addr_q + i_step;

    // backward stops at zero instead of wrapping
    assign below_step = (addr_q < i_step);
    assign addr_bwd   = below_step ? '0 : (addr_q - i_step);

    // backward play starts from the end of the recording
    assign addr_start = i_backward ? i_max_addr : '0;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            addr_q <= '0;
        end else if (i_load_start) begin
            addr_q <= addr_start;
        end else if (i_clear) begin
            addr_q <= '0;
        end else if (i_tick && i_advance) begin
            if (i_backward) begin
                addr_q <= addr_bwd;
            end else begin
                addr_q <= addr_fwd;
            end
        end
    end

    assign o_sram_addr = addr_q;   // SRAM returns data for this address

endmodule

//--- aud_dsp.sv
`timescale 1ns/1ps

`include "aud_dsp_config.svh"

module aud_dsp (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_start,
    input  logic                    i_pause,
    input  logic                    i_stop,
    input  logic [`AUD_SPEED_W-1:0] i_speed,
    input  logic                    i_fast,
    input  logic                    i_slow_hold,
    input  logic                    i_slow_linear,
    input  logic                    i_play_backward,
    input  aud_sample_pkg::addr_t   i_max_addr,
    input  logic                    i_daclrck,
    input  aud_sample_pkg::sample_t i_sram_data,
    output aud_sample_pkg::sample_t o_dac_data,
    output aud_sample_pkg::addr_t   o_sram_addr
);

    logic                     tick;
    logic                     load_start;
    logic                     clear;
    aud_ctrl_pkg::play_mode_e play_mode;
    logic                     advance;
    aud_sample_pkg::addr_t    step;

    // transport and mode decode
    aud_play_ctrl ctrl_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_start       (i_start),
        .i_pause       (i_pause),
        .i_stop        (i_stop),
        .i_daclrck     (i_daclrck),
        .i_fast        (i_fast),
        .i_slow_hold   (i_slow_hold),
        .i_slow_linear (i_slow_linear),
        .o_tick        (tick),
        .o_load_start  (load_start),
        .o_clear       (clear),
        .o_play_mode   (play_mode)
    );

    aud_sample_engine engine_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_tick      (tick),
        .i_clear     (clear),
        .i_play_mode (play_mode),
        .i_speed     (i_speed),
        .i_sram_data (i_sram_data),
        .o_advance   (advance),
        .o_step      (step),
        .o_dac_data  (o_dac_data)
    );

    // read pointer into the recording
    aud_addr_gen addr_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_tick       (tick),
        .i_load_start (load_start),
        .i_clear      (clear),
        .i_backward   (i_play_backward),
        .i_max_addr   (i_max_addr),
        .i_advance    (advance),
        .i_step       (step),
        .o_sram_addr  (o_sram_addr)
    );

endmodule

//--- aud_dsp_properties.sv
`timescale 1ns/1ps

module aud_dsp_properties (
    input logic                  i_clk,
    input logic                  i_rst_n,
    input logic                  i_tick,
    input logic                  i_load_start,
    input logic                  i_clear,
    input aud_sample_pkg::addr_t i_sram_addr
);

    // address only moves on tick, load or clear
    addr_stable_a: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (!i_tick && !i_load_start && !i_clear) |=> $stable(i_sram_addr)
    ) else $error("sram address changed without tick, load or clear");

    tick_exclusive_a: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(i_tick && (i_load_start || i_clear))
    ) else $error("tick overlaps load or clear");

    clear_zero_a: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_clear |=> (i_sram_addr == '0)
    ) else $error("sram address not zero one cycle after clear");

endmodule

bind aud_dsp aud_dsp_properties props_i (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_tick       (tick),
    .i_load_start (load_start),
    .i_clear      (clear),
    .i_sram_addr  (o_sram_addr)
);

//--- aud_dsp_tb.sv
`timescale 1ns/1ps

`include "aud_dsp_config.svh"

module aud_dsp_tb;

    localparam int PAUSE_PERIODS = 3;
    localparam int XP_NONE  = 0;
    localparam int XP_PAUSE = 1;   // pause halfway, then resume
    localparam int XP_STOP  = 2;   // pause halfway, stop, start again

    typedef struct packed {
        logic [2:0]              pins;       // fast, slow hold, slow linear
        logic [`AUD_SPEED_W-1:0] speed;
        logic                    back;
        aud_sample_pkg::addr_t   max_addr;
        int                      periods;
        int                      xport;
        aud_sample_pkg::addr_t   exp_addr;   // address after the last period
    } test_t;

    logic                    i_clk;
    logic                    i_rst_n;
    logic                    i_start;
    logic                    i_pause;
    logic                    i_stop;
    logic [`AUD_SPEED_W-1:0] i_speed;
    logic                    i_fast;
    logic                    i_slow_hold;
    logic                    i_slow_linear;
    logic                    i_play_backward;
    aud_sample_pkg::addr_t   i_max_addr;
    logic                    i_daclrck = 1'b0;
    aud_sample_pkg::sample_t i_sram_data;
    aud_sample_pkg::sample_t o_dac_data;
    aud_sample_pkg::addr_t   o_sram_addr;

    logic [2:0]              lrck_cnt = 3'd0;   // zero in the tick cycle
    aud_sample_pkg::sample_t sram_mem [0:255];
    logic                    table_ready = 1'b0;
    test_t                   tests [$];
    string                   names [$];
    test_t                   cur;
    string                   cur_name;
    int                      test_errors;
    int                      pass_count;
    int                      fail_count;

    // reference model state
    aud_sample_pkg::addr_t   m_addr;
    aud_sample_pkg::sample_t m_prev;
    aud_sample_pkg::sample_t m_curr;
    aud_sample_pkg::sample_t m_out;
    int                      m_cnt;

    aud_dsp dut_i (.*);

    assign i_sram_data = sram_mem[o_sram_addr[7:0]];   // async SRAM read

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // lrck high for 4 clocks, low for 4
    always @(posedge i_clk) begin
        lrck_cnt  <= lrck_cnt + 3'd1;
        i_daclrck <= ((lrck_cnt + 3'd1) < 3'd4);
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // galois, right shift
    endfunction

    task automatic fill_sram();
        logic [31:0] lfsr;
        logic [15:0] word;
        int          a;
        int          b;
        lfsr = 32'hc1c4;
        for (a = 0; a < 256; a++) begin
            word = '0;
            for (b = 0; b < 16; b++) begin
                word = {word[14:0], lfsr[0]};   // one step per bit
                lfsr = lfsr_next(lfsr);
            end
            sram_mem[a[7:0]] = word;
        end
    endtask

    function automatic void add_test(input string name, input logic [2:0] pins,
                                     input logic [`AUD_SPEED_W-1:0] speed, input logic back,
                                     input aud_sample_pkg::addr_t max_addr, input int periods,
                                     input int xport, input aud_sample_pkg::addr_t exp_addr);
        test_t e;
        e.pins     = pins;
        e.speed    = speed;
        e.back     = back;
        e.max_addr = max_addr;
        e.periods  = periods;
        e.xport    = xport;
        e.exp_addr = exp_addr;
        names.push_back(name);
        tests.push_back(e);
    endfunction

    function automatic void build_table();
        add_test("normal_fwd",        3'b000, 3'd0, 1'b0, 20'd0,   10, XP_NONE,  20'd10);
        add_test("normal_bwd_clamp",  3'b000, 3'd0, 1'b1, 20'd6,    9, XP_NONE,  20'd0);
        add_test("fast_s0_fwd",       3'b100, 3'd0, 1'b0, 20'd0,    6, XP_NONE,  20'd6);
        add_test("fast_s3_fwd",       3'b100, 3'd3, 1'b0, 20'd0,    5, XP_NONE,  20'd20);
        add_test("fast_s3_bwd",       3'b100, 3'd3, 1'b1, 20'd200,  6, XP_NONE,  20'd176);
        add_test("fast_s7_bwd_clamp", 3'b100, 3'd7, 1'b1, 20'd30,   5, XP_NONE,  20'd0);
        add_test("fast_s7_fwd_long",  3'b100, 3'd7, 1'b0, 20'd0,   40, XP_NONE,  20'd320);
        add_test("hold_s1_fwd",       3'b010, 3'd1, 1'b0, 20'd0,    8, XP_NONE,  20'd4);
        add_test("hold_s4_bwd",       3'b010, 3'd4, 1'b1, 20'd100, 12, XP_NONE,  20'd98);
        add_test("linear_s2_fwd",     3'b001, 3'd2, 1'b0, 20'd0,   12, XP_NONE,  20'd4);
        add_test("linear_s7_fwd",     3'b001, 3'd7, 1'b0, 20'd0,   20, XP_NONE,  20'd2);
        add_test("fast_over_slow",    3'b111, 3'd2, 1'b0, 20'd0,    5, XP_NONE,  20'd15);
        add_test("hold_over_linear",  3'b011, 3'd2, 1'b0, 20'd0,    7, XP_NONE,  20'd2);
        add_test("pause_resume",      3'b000, 3'd0, 1'b0, 20'd0,   10, XP_PAUSE, 20'd10);
        add_test("linear_pause",      3'b001, 3'd2, 1'b0, 20'd0,    9, XP_PAUSE, 20'd3);
        add_test("stop_in_pause",     3'b000, 3'd0, 1'b1, 20'd50,   8, XP_STOP,  20'd46);
    endfunction

    // one lrck period of the player, updates the expected outputs
    task automatic model_tick();
        aud_sample_pkg::sample_t data;
        aud_sample_pkg::addr_t   step;
        logic                    adv;
        int                      n;
        int                      lin;
        data = sram_mem[m_addr[7:0]];
        n    = int'(cur.speed) + 1;
        step = 20'd1;
        adv  = 1'b1;
        if (cur.pins[2]) begin   // fast beats both slow pins
            step   = aud_sample_pkg::addr_t'(n);
            m_curr = data;
            m_out  = data;
            m_cnt  = 0;
        end else if (cur.pins[1:0] == 2'b00) begin
            m_curr = data;
            m_out  = data;
        end else begin
            if (cur.pins[1]) begin
                m_out = m_curr;   // hold wins over linear
            end else begin
                lin   = int'(m_prev) + ((int'(m_curr) - int'(m_prev)) * (m_cnt + 1)) / n;
                m_out = lin[`AUD_SAMPLE_W-1:0];
            end
            adv = (m_cnt == n - 1);
            if (adv) begin
                m_prev = m_curr;
                m_curr = data;
                m_cnt  = 0;
            end else begin
                m_cnt = m_cnt + 1;
            end
        end
        if (adv && cur.back) begin
            m_addr = (m_addr < step) ? '0 : (m_addr - step);
        end else if (adv) begin
            m_addr = m_addr + step;
        end
    endtask

    task automatic check_outputs(input string what);
        if (o_dac_data !== m_out) begin
            $display("Mismatch %s %s dac: expected %h, actual %h",
                     cur_name, what, m_out, o_dac_data);
            test_errors++;
        end
        if (o_sram_addr !== m_addr) begin
            $display("Mismatch %s %s addr: expected %h, actual %h",
                     cur_name, what, m_addr, o_sram_addr);
            test_errors++;
        end
    endtask

    task automatic play_periods(input int count);
        int p;
        for (p = 0; p < count; p++) begin
            while (lrck_cnt != 3'd0) begin
                @(negedge i_clk);
            end
            model_tick();
            @(negedge i_clk);   // registers took the tick
            check_outputs($sformatf("period %0d", p));
        end
    endtask

    task automatic stop_player();
        @(posedge i_clk);
        i_stop <= 1'b1;
        @(posedge i_clk);
        i_stop <= 1'b0;
        m_addr = '0;
        m_cnt  = 0;   // samples are kept
        @(negedge i_clk);
        check_outputs("after stop");
    endtask

    task automatic start_player(input logic reload);
        @(posedge i_clk);
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        if (reload) begin
            m_addr = cur.back ? cur.max_addr : '0;
        end
        @(negedge i_clk);
        check_outputs("after start");
    endtask

    task automatic pause_hold();
        int c;
        @(posedge i_clk);
        i_pause <= 1'b1;
        @(posedge i_clk);
        i_pause <= 1'b0;
        for (c = 0; c < PAUSE_PERIODS * 8; c++) begin
            @(negedge i_clk);
            check_outputs("paused");
        end
    endtask

    task automatic run_test(input int t);
        int half;
        cur         = tests[t];
        cur_name    = names[t];
        test_errors = 0;
        stop_player();
        @(posedge i_clk);
        {i_fast, i_slow_hold, i_slow_linear} <= cur.pins;
        i_speed         <= cur.speed;
        i_play_backward <= cur.back;
        i_max_addr      <= cur.max_addr;
        start_player(1'b1);
        half = (cur.xport == XP_NONE) ? cur.periods : cur.periods / 2;
        play_periods(half);
        if (cur.xport != XP_NONE) begin
            pause_hold();
            if (cur.xport == XP_STOP) begin
                stop_player();
            end
            start_player(cur.xport == XP_STOP);
            play_periods(cur.periods - half);
        end
        if (o_sram_addr !== cur.exp_addr) begin
            $display("Mismatch %s final addr: expected %h, actual %h",
                     cur_name, cur.exp_addr, o_sram_addr);
            test_errors++;
        end
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s: ok", cur_name);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", cur_name, test_errors);
        end
    endtask

    initial begin : main
        int t;
        i_rst_n         = 1'b0;
        i_start         = 1'b0;
        i_pause         = 1'b0;
        i_stop          = 1'b0;
        i_speed         = '0;
        i_fast          = 1'b0;
        i_slow_hold     = 1'b0;
        i_slow_linear   = 1'b0;
        i_play_backward = 1'b0;
        i_max_addr      = '0;
        m_addr          = '0;
        m_prev          = '0;
        m_curr          = '0;
        m_out           = '0;
        m_cnt           = 0;
        pass_count      = 0;
        fail_count      = 0;
        build_table();
        fill_sram();
        table_ready = 1'b1;
        repeat (16) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        for (t = 0; t < tests.size(); t++) begin
            run_test(t);
        end
        $display("summary: %0d tests ok, %0d tests with errors", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // run length from the table, 8 clocks per lrck period
    initial begin : watchdog
        longint limit_ns;
        int     t;
        wait (table_ready);
        limit_ns = 16 * 100 + 20000;   // reset plus margin
        for (t = 0; t < tests.size(); t++) begin
            limit_ns += longint'(tests[t].periods + PAUSE_PERIODS + 4) * 8 * 100;
        end
        #(limit_ns);
        $display("watchdog expired before all tests finished");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- aud_dsp.f
+incdir+.
aud_ctrl_pkg.sv
aud_sample_pkg.sv
aud_play_ctrl.sv
aud_sample_engine.sv
aud_addr_gen.sv
aud_dsp.sv
aud_dsp_properties.sv
aud_dsp_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= aud_dsp_tb
FILELIST  ?= aud_dsp.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard *.sv) $(wildcard *.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
